/* design/pip_pkg.sv */
package pip_pkg;

  // Datapath and instruction width
  localparam int unsigned DATA_W = 32;
  // Register index width
  localparam int unsigned REG_W  = 5;

  typedef logic [REG_W-1:0]  reg_idx_t;
  typedef logic [DATA_W-1:0] word_t;

  // Major opcodes, inst[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f
  } opcode_t;

  // SPECIAL function codes, inst[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_t;

  // Which ALU unit drives the result
  typedef enum logic [1:0] {
    RES_ADD,
    RES_LOGIC,
    RES_CMP,
    RES_SHIFT
  } res_sel_t;

endpackage

/* design/pip_fetch.sv */
`timescale 1ns/1ps

module pip_fetch #(
  parameter int unsigned       ADDR_W   = 32,
  parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
  input  logic              clock_i,
  input  logic              rst_n_i,
  output logic [ADDR_W-1:0] icache_addr_o,
  output logic              icache_rd_o,
  input  pip_pkg::word_t    icache_data_i,
  input  logic              icache_waitrequest_i,
  output pip_pkg::word_t    fetch_inst_o,
  output logic              fetch_valid_o
);

  logic [ADDR_W-1:0] pc_q;
  logic              rd_q;
  logic              accept;

  assign icache_addr_o = pc_q;
  assign icache_rd_o   = rd_q;
  assign accept        = rd_q & ~icache_waitrequest_i;

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      pc_q          <= RESET_PC;
      rd_q          <= 1'b0;
      fetch_valid_o <= 1'b0;
    end else begin
      rd_q          <= 1'b1;
      // Bubble whenever the cache holds us off
      fetch_valid_o <= accept;
      if (accept) begin
        pc_q <= pc_q + ADDR_W'(4);
      end
    end
  end

  // Instruction word only moves on acceptance
  always_ff @(posedge clock_i) begin
    if (accept) begin
      fetch_inst_o <= icache_data_i;
    end
  end

endmodule

/* design/pip_alu.sv */
`timescale 1ns/1ps

module pip_alu (
  input  pip_pkg::alu_op_t alu_op_i,
  input  pip_pkg::word_t   a_i,
  input  pip_pkg::word_t   b_i,
  input  logic [4:0]       shamt_i,
  output pip_pkg::word_t   result_o
);
  import pip_pkg::*;

  res_sel_t res_sel;
  logic     sub;
  word_t    b_add;
  word_t    sum;
  logic     less;
  word_t    logic_res;
  word_t    shift_res;

  // Single adder, subtract by inverting B and carrying in
  assign sub   = (alu_op_i == ALU_SUB);
  assign b_add = sub ? ~b_i : b_i;
  assign sum   = a_i + b_add + word_t'(sub);

  always_comb begin
    if (alu_op_i == ALU_SLT) begin
      less = $signed(a_i) < $signed(b_i);
    end else begin
      less = a_i < b_i;
    end
  end

  always_comb begin
    case (alu_op_i)
      ALU_AND: logic_res = a_i & b_i;
      ALU_OR:  logic_res = a_i | b_i;
      ALU_XOR: logic_res = a_i ^ b_i;
      default: logic_res = ~(a_i | b_i);
    endcase
  end

  // Shifts act on B
  always_comb begin
    case (alu_op_i)
      ALU_SRL: shift_res = b_i >> shamt_i;
      ALU_SRA: shift_res = $signed(b_i) >>> shamt_i;
      ALU_LUI: shift_res = {b_i[15:0], 16'h0000};
      default: shift_res = b_i << shamt_i;
    endcase
  end

  always_comb begin
    case (alu_op_i)
      ALU_ADD, ALU_SUB:                   res_sel = RES_ADD;
      ALU_SLT, ALU_SLTU:                  res_sel = RES_CMP;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI: res_sel = RES_SHIFT;
      default:                            res_sel = RES_LOGIC;
    endcase
  end

  always_comb begin
    case (res_sel)
      RES_ADD:   result_o = sum;
      RES_CMP:   result_o = word_t'(less);
      RES_SHIFT: result_o = shift_res;
      default:   result_o = logic_res;
    endcase
  end

endmodule

/* design/pip_decode.sv */
`timescale 1ns/1ps

module pip_decode (
  input  logic              clock_i,
  input  logic              rst_n_i,
  input  pip_pkg::word_t    fetch_inst_i,
  input  logic              fetch_valid_i,
  output pip_pkg::reg_idx_t rfile_rd_addr1_o,
  output pip_pkg::reg_idx_t rfile_rd_addr2_o,
  input  pip_pkg::word_t    rfile_rd_data1_i,
  input  pip_pkg::word_t    rfile_rd_data2_i,
  input  pip_pkg::reg_idx_t wb_addr_i,
  input  logic              wb_enable_i,
  input  pip_pkg::word_t    wb_data_i,
  output pip_pkg::word_t    ex_a_o,
  output pip_pkg::word_t    ex_b_o,
  output pip_pkg::word_t    ex_imm_o,
  output pip_pkg::reg_idx_t ex_a_reg_o,
  output pip_pkg::reg_idx_t ex_b_reg_o,
  output pip_pkg::reg_idx_t ex_dest_reg_o,
  output logic              ex_use_imm_o,
  output logic              ex_dest_valid_o,
  output logic [4:0]        ex_shamt_o,
  output pip_pkg::alu_op_t  ex_alu_op_o
);
  import pip_pkg::*;

  opcode_t  opcode;
  funct_t   funct;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    sext_imm;
  word_t    zext_imm;

  alu_op_t  alu_op;
  logic     use_imm;
  logic     known;
  word_t    imm;
  reg_idx_t dest;
  word_t    a_val;
  word_t    b_val;

  // Field split
  assign opcode   = opcode_t'(fetch_inst_i[31:26]);
  assign funct    = funct_t'(fetch_inst_i[5:0]);
  assign rs       = fetch_inst_i[25:21];
  assign rt       = fetch_inst_i[20:16];
  assign rd       = fetch_inst_i[15:11];
  assign sext_imm = {{16{fetch_inst_i[15]}}, fetch_inst_i[15:0]};
  assign zext_imm = {16'h0000, fetch_inst_i[15:0]};

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  // Immediate forms write rt, SPECIAL writes rd
  assign use_imm = (opcode != OP_SPECIAL);
  assign dest    = use_imm ? rt : rd;

  always_comb begin
    alu_op = ALU_ADD;
    imm    = zext_imm;
    known  = 1'b1;
    case (opcode)
      OP_SPECIAL: begin
        case (funct)
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_SRA:  alu_op = ALU_SRA;
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_NOR:  alu_op = ALU_NOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          default: known = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        alu_op = ALU_ADD;
        imm    = sext_imm;
      end
      OP_SLTI: begin
        alu_op = ALU_SLT;
        imm    = sext_imm;
      end
      OP_SLTIU: begin
        alu_op = ALU_SLTU;
        imm    = sext_imm;
      end
      OP_ANDI: alu_op = ALU_AND;
      OP_ORI:  alu_op = ALU_OR;
      OP_XORI: alu_op = ALU_XOR;
      // Raw half word, the ALU moves it up
      OP_LUI:  alu_op = ALU_LUI;
      default: known = 1'b0;
    endcase
  end

  // Write-back bypass, the register file only updates on the next edge
  assign a_val = (wb_enable_i && wb_addr_i == rs) ? wb_data_i : rfile_rd_data1_i;
  assign b_val = (wb_enable_i && wb_addr_i == rt) ? wb_data_i : rfile_rd_data2_i;

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      ex_dest_valid_o <= 1'b0;
    end else begin
      ex_dest_valid_o <= fetch_valid_i && known && (dest != '0);
    end
  end

  always_ff @(posedge clock_i) begin
    ex_a_o        <= a_val;
    ex_b_o        <= b_val;
    ex_imm_o      <= imm;
    ex_a_reg_o    <= rs;
    ex_b_reg_o    <= rt;
    ex_dest_reg_o <= dest;
    ex_use_imm_o  <= use_imm;
    ex_shamt_o    <= fetch_inst_i[10:6];
    ex_alu_op_o   <= alu_op;
  end

endmodule

/* design/pip_execute.sv */
`timescale 1ns/1ps

module pip_execute (
  input  logic              clock_i,
  input  logic              rst_n_i,
  input  pip_pkg::word_t    ex_a_i,
  input  pip_pkg::word_t    ex_b_i,
  input  pip_pkg::word_t    ex_imm_i,
  input  pip_pkg::reg_idx_t ex_a_reg_i,
  input  pip_pkg::reg_idx_t ex_b_reg_i,
  input  pip_pkg::reg_idx_t ex_dest_reg_i,
  input  logic              ex_use_imm_i,
  input  logic              ex_dest_valid_i,
  input  logic [4:0]        ex_shamt_i,
  input  pip_pkg::alu_op_t  ex_alu_op_i,
  output pip_pkg::reg_idx_t rfile_wr_addr1_o,
  output logic              rfile_wr_enable1_o,
  output pip_pkg::word_t    rfile_wr_data1_o
);
  import pip_pkg::*;

  word_t a_fwd;
  word_t b_fwd;
  word_t b_op;
  word_t alu_result;
  logic  fwd_a;
  logic  fwd_b;

  // Distance-1 dependence, take the previous result straight back
  assign fwd_a = rfile_wr_enable1_o && (rfile_wr_addr1_o == ex_a_reg_i);
  assign fwd_b = rfile_wr_enable1_o && (rfile_wr_addr1_o == ex_b_reg_i);

  assign a_fwd = fwd_a ? rfile_wr_data1_o : ex_a_i;
  assign b_fwd = fwd_b ? rfile_wr_data1_o : ex_b_i;
  assign b_op  = ex_use_imm_i ? ex_imm_i : b_fwd;

  pip_alu u_alu (
    .alu_op_i (ex_alu_op_i),
    .a_i      (a_fwd),
    .b_i      (b_op),
    .shamt_i  (ex_shamt_i),
    .result_o (alu_result)
  );

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      rfile_wr_enable1_o <= 1'b0;
    end else begin
      rfile_wr_enable1_o <= ex_dest_valid_i;
    end
  end

  // Result register doubles as the write port
  always_ff @(posedge clock_i) begin
    rfile_wr_addr1_o <= ex_dest_reg_i;
    rfile_wr_data1_o <= alu_result;
  end

endmodule

/* design/pipeline.sv */
`timescale 1ns/1ps

module pipeline #(
  parameter int unsigned       ADDR_W   = 32,
  parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
  input  logic              clock_i,
  input  logic              rst_n_i,

  // Instruction cache
  output logic [ADDR_W-1:0] icache_addr_o,
  output logic              icache_rd_o,
  input  pip_pkg::word_t    icache_data_i,
  input  logic              icache_waitrequest_i,

  // Register file read
  output pip_pkg::reg_idx_t rfile_rd_addr1_o,
  output pip_pkg::reg_idx_t rfile_rd_addr2_o,
  input  pip_pkg::word_t    rfile_rd_data1_i,
  input  pip_pkg::word_t    rfile_rd_data2_i,

  // Register file write
  output pip_pkg::reg_idx_t rfile_wr_addr1_o,
  output logic              rfile_wr_enable1_o,
  output pip_pkg::word_t    rfile_wr_data1_o
);
  import pip_pkg::*;

  word_t    fetch_inst;
  logic     fetch_valid;

  word_t    ex_a;
  word_t    ex_b;
  word_t    ex_imm;
  reg_idx_t ex_a_reg;
  reg_idx_t ex_b_reg;
  reg_idx_t ex_dest_reg;
  logic     ex_use_imm;
  logic     ex_dest_valid;
  logic [4:0] ex_shamt;
  alu_op_t  ex_alu_op;

  pip_fetch #(
    .ADDR_W   (ADDR_W),
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clock_i              (clock_i),
    .rst_n_i              (rst_n_i),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .fetch_inst_o         (fetch_inst),
    .fetch_valid_o        (fetch_valid)
  );

  // Write port loops back into decode for the distance-2 bypass
  pip_decode u_decode (
    .clock_i          (clock_i),
    .rst_n_i          (rst_n_i),
    .fetch_inst_i     (fetch_inst),
    .fetch_valid_i    (fetch_valid),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .wb_addr_i        (rfile_wr_addr1_o),
    .wb_enable_i      (rfile_wr_enable1_o),
    .wb_data_i        (rfile_wr_data1_o),
    .ex_a_o           (ex_a),
    .ex_b_o           (ex_b),
    .ex_imm_o         (ex_imm),
    .ex_a_reg_o       (ex_a_reg),
    .ex_b_reg_o       (ex_b_reg),
    .ex_dest_reg_o    (ex_dest_reg),
    .ex_use_imm_o     (ex_use_imm),
    .ex_dest_valid_o  (ex_dest_valid),
    .ex_shamt_o       (ex_shamt),
    .ex_alu_op_o      (ex_alu_op)
  );

  pip_execute u_execute (
    .clock_i            (clock_i),
    .rst_n_i            (rst_n_i),
    .ex_a_i             (ex_a),
    .ex_b_i             (ex_b),
    .ex_imm_i           (ex_imm),
    .ex_a_reg_i         (ex_a_reg),
    .ex_b_reg_i         (ex_b_reg),
    .ex_dest_reg_i      (ex_dest_reg),
    .ex_use_imm_i       (ex_use_imm),
    .ex_dest_valid_i    (ex_dest_valid),
    .ex_shamt_i         (ex_shamt),
    .ex_alu_op_i        (ex_alu_op),
    .rfile_wr_addr1_o   (rfile_wr_addr1_o),
    .rfile_wr_enable1_o (rfile_wr_enable1_o),
    .rfile_wr_data1_o   (rfile_wr_data1_o)
  );

endmodule

/* bench/pip_checker.sv */
`timescale 1ns/1ps

module pip_checker #(
  parameter logic [31:0] RESET_PC = '0
) (
  input  logic              clock_i,
  input  logic              rst_n_i,
  input  logic [31:0]       icache_addr_i,
  input  logic              icache_rd_i,
  input  logic              icache_waitrequest_i,
  input  pip_pkg::word_t    icache_data_i,
  input  pip_pkg::reg_idx_t wr_addr_i,
  input  logic              wr_enable_i,
  input  pip_pkg::word_t    wr_data_i,
  input  logic              end_check_i,
  output int                errors_o,
  output int                writes_o
);
  import pip_pkg::*;

  word_t       model_rf [32];
  reg_idx_t    exp_addr_q [$];
  word_t       exp_data_q [$];
  logic [31:0] exp_pc;
  int          errors = 0;
  int          writes = 0;

  assign errors_o = errors;
  assign writes_o = writes;

  // Architectural effect of one accepted instruction
  task automatic execute_model(input word_t inst);
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] sa;
    reg_idx_t   dest;
    word_t      s;
    word_t      t;
    word_t      sext;
    word_t      zext;
    word_t      res;
    logic       writes_reg;
    op         = inst[31:26];
    fn         = inst[5:0];
    sa         = inst[10:6];
    s          = model_rf[inst[25:21]];
    t          = model_rf[inst[20:16]];
    sext       = {{16{inst[15]}}, inst[15:0]};
    zext       = {16'h0000, inst[15:0]};
    res        = '0;
    writes_reg = 1'b1;
    if (op == OP_SPECIAL) begin
      dest = inst[15:11];
      case (fn)
        FN_SLL:  res = t << sa;
        FN_SRL:  res = t >> sa;
        FN_SRA:  res = $signed(t) >>> sa;
        FN_ADDU: res = s + t;
        FN_SUBU: res = s - t;
        FN_AND:  res = s & t;
        FN_OR:   res = s | t;
        FN_XOR:  res = s ^ t;
        FN_NOR:  res = ~(s | t);
        FN_SLT:  res = {31'd0, $signed(s) < $signed(t)};
        FN_SLTU: res = {31'd0, s < t};
        default: writes_reg = 1'b0;
      endcase
    end else begin
      dest = inst[20:16];
      case (op)
        OP_ADDIU: res = s + sext;
        OP_SLTI:  res = {31'd0, $signed(s) < $signed(sext)};
        OP_SLTIU: res = {31'd0, s < sext};
        OP_ANDI:  res = s & zext;
        OP_ORI:   res = s | zext;
        OP_XORI:  res = s ^ zext;
        OP_LUI:   res = {inst[15:0], 16'h0000};
        default:  writes_reg = 1'b0;
      endcase
    end
    if (writes_reg && dest != 5'd0) begin
      model_rf[dest] = res;
      exp_addr_q.push_back(dest);
      exp_data_q.push_back(res);
    end
  endtask

  task automatic compare_write();
    reg_idx_t exp_addr;
    word_t    exp_data;
    if (exp_addr_q.size() == 0) begin
      $display("unexpected write to r%0d at time %0t: no instruction was owed a write",
               wr_addr_i, $time);
      errors++;
    end else begin
      exp_addr = exp_addr_q.pop_front();
      exp_data = exp_data_q.pop_front();
      writes++;
      if (wr_addr_i !== exp_addr || wr_data_i !== exp_data) begin
        $display("mismatch at time %0t: write r%0d = %08h, expected r%0d = %08h",
                 $time, wr_addr_i, wr_data_i, exp_addr, exp_data);
        errors++;
      end
    end
  endtask

  always @(posedge clock_i) begin
    if (!rst_n_i) begin
      for (int k = 0; k < 32; k++) begin
        model_rf[k] = word_t'(k) * 32'h01010101;
      end
      exp_pc = RESET_PC;
      exp_addr_q.delete();
      exp_data_q.delete();
    end else begin
      // Writes before this edge's instruction so an empty queue stays empty
      if (wr_enable_i === 1'b1) begin
        compare_write();
      end
      if (icache_rd_i === 1'b1 && icache_waitrequest_i === 1'b0) begin
        if (icache_addr_i !== exp_pc) begin
          $display("mismatch at time %0t: fetch address %08h, expected %08h",
                   $time, icache_addr_i, exp_pc);
          errors++;
        end
        exp_pc = exp_pc + 32'd4;
        execute_model(icache_data_i);
      end
      if (end_check_i === 1'b1 && exp_addr_q.size() != 0) begin
        $display("%0d expected writes never appeared by the end of the test at time %0t",
                 exp_addr_q.size(), $time);
        errors++;
        exp_addr_q.delete();
        exp_data_q.delete();
      end
    end
  end

endmodule

/* bench/tb_pipeline.sv */
`timescale 1ns/1ps

module tb_pipeline;
  import pip_pkg::*;

  localparam int          NUM_TESTS      = 5;
  localparam int          BODY_LEN       = 200;
  localparam int          PROG_LEN       = 204;
  localparam int          IMEM_WORDS     = 256;
  localparam int          TIMEOUT_CYCLES = NUM_TESTS * (PROG_LEN * 4 + 20);
  localparam logic [31:0] RESET_PC       = 32'h0000_0000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] icache_addr;
  logic        icache_rd;
  word_t       icache_data;
  logic        icache_waitrequest;
  reg_idx_t    rd_addr1;
  reg_idx_t    rd_addr2;
  word_t       rd_data1;
  word_t       rd_data2;
  reg_idx_t    wr_addr;
  logic        wr_enable;
  word_t       wr_data;
  logic        end_check;
  int          chk_errors;
  int          chk_writes;

  word_t       imem [IMEM_WORDS];
  word_t       rfile [32];
  logic [31:0] rng_state;
  logic        random_wait;
  int          bench_errors;
  int          accepted = 0;
  int          cycles = 0;

  pipeline #(
    .ADDR_W   (32),
    .RESET_PC (RESET_PC)
  ) u_pipeline (
    .clock_i              (clk),
    .rst_n_i              (rst_n),
    .icache_addr_o        (icache_addr),
    .icache_rd_o          (icache_rd),
    .icache_data_i        (icache_data),
    .icache_waitrequest_i (icache_waitrequest),
    .rfile_rd_addr1_o     (rd_addr1),
    .rfile_rd_addr2_o     (rd_addr2),
    .rfile_rd_data1_i     (rd_data1),
    .rfile_rd_data2_i     (rd_data2),
    .rfile_wr_addr1_o     (wr_addr),
    .rfile_wr_enable1_o   (wr_enable),
    .rfile_wr_data1_o     (wr_data)
  );

  pip_checker #(
    .RESET_PC (RESET_PC)
  ) u_checker (
    .clock_i              (clk),
    .rst_n_i              (rst_n),
    .icache_addr_i        (icache_addr),
    .icache_rd_i          (icache_rd),
    .icache_waitrequest_i (icache_waitrequest),
    .icache_data_i        (icache_data),
    .wr_addr_i            (wr_addr),
    .wr_enable_i          (wr_enable),
    .wr_data_i            (wr_data),
    .end_check_i          (end_check),
    .errors_o             (chk_errors),
    .writes_o             (chk_writes)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t fetch_word(input logic [31:0] addr);
    if ($isunknown(addr) || addr[31:2] >= IMEM_WORDS) begin
      return '0;
    end
    return imem[addr[9:2]];
  endfunction

  function automatic word_t read_reg(input reg_idx_t addr);
    if ($isunknown(addr)) begin
      return '0;
    end
    return rfile[addr];
  endfunction

  function automatic logic [5:0] pick_funct(input logic [3:0] k);
    case (k)
      4'd0:    return FN_SLL;
      4'd1:    return FN_SRL;
      4'd2:    return FN_SRA;
      4'd3:    return FN_ADDU;
      4'd4:    return FN_SUBU;
      4'd5:    return FN_AND;
      4'd6:    return FN_OR;
      4'd7:    return FN_XOR;
      4'd8:    return FN_NOR;
      4'd9:    return FN_SLT;
      default: return FN_SLTU;
    endcase
  endfunction

  function automatic logic funct_known(input logic [5:0] fn);
    case (fn)
      FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND,
      FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic opcode_known(input logic [5:0] op);
    return (op == OP_SPECIAL) || (op >= OP_ADDIU && op <= OP_LUI);
  endfunction

  // Cache and register file answer for the current addresses
  always @(negedge clk) begin
    icache_data <= fetch_word(icache_addr);
    rd_data1    <= read_reg(rd_addr1);
    rd_data2    <= read_reg(rd_addr2);
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < 32; k++) begin
        rfile[k] <= word_t'(k) * 32'h01010101;
      end
    end else if (wr_enable === 1'b1 && wr_addr != 5'd0) begin
      rfile[wr_addr] <= wr_data;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (!rst_n) begin
      accepted = 0;
    end else if (icache_rd === 1'b1 && icache_waitrequest === 1'b0) begin
      accepted = accepted + 1;
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  // Wait request on about a third of cycles when enabled
  task automatic step_cycle();
    logic [31:0] r;
    @(negedge clk);
    if (random_wait) begin
      draw_random(r);
      icache_waitrequest = (r % 3 == 0);
    end else begin
      icache_waitrequest = 1'b0;
    end
  endtask

  task automatic make_rtype(output word_t inst);
    logic [31:0] r;
    logic [5:0]  fn;
    logic [4:0]  sa;
    draw_random(r);
    fn   = pick_funct(4'(r[31:28] % 11));
    sa   = (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) ? r[10:6] : 5'd0;
    inst = {OP_SPECIAL, r[25:21], r[20:16], r[15:11], sa, fn};
  endtask

  task automatic make_itype(output word_t inst);
    logic [31:0] r;
    logic [5:0]  op;
    draw_random(r);
    op   = 6'(OP_ADDIU + r[31:29] % 7);
    inst = {op, r[25:21], r[20:16], r[15:0]};
  endtask

  task automatic make_mixed(output word_t inst);
    logic [31:0] r;
    draw_random(r);
    if (r[0]) begin
      make_rtype(inst);
    end else begin
      make_itype(inst);
    end
  endtask

  // Registers 1 to 3 only so most operands hit a recent result
  task automatic make_chain(output word_t inst);
    logic [31:0] r;
    draw_random(r);
    if (r[0]) begin
      make_rtype(inst);
      inst[15:11] = 5'(1 + r[15:10] % 3);
    end else begin
      make_itype(inst);
    end
    inst[25:21] = 5'(1 + r[9:4] % 3);
    inst[20:16] = 5'(1 + r[21:16] % 3);
  endtask

  task automatic make_faulty(output word_t inst);
    logic [31:0] r;
    draw_random(r);
    make_mixed(inst);
    case (r[2:0])
      3'd0: begin
        if (inst[31:26] == OP_SPECIAL) begin
          inst[15:11] = 5'd0;
        end else begin
          inst[20:16] = 5'd0;
        end
      end
      3'd1: inst[31:26] = opcode_known(r[13:8]) ? 6'h3f : r[13:8];
      3'd2: begin
        inst[31:26] = OP_SPECIAL;
        inst[5:0]   = funct_known(r[19:14]) ? 6'h3f : r[19:14];
      end
      default: ;
    endcase
  endtask

  task automatic fill_program(input int test_no);
    word_t inst;
    for (int k = 0; k < IMEM_WORDS; k++) begin
      if (k < BODY_LEN) begin
        case (test_no)
          1:       make_rtype(inst);
          2:       make_itype(inst);
          3:       make_chain(inst);
          4:       make_mixed(inst);
          default: make_faulty(inst);
        endcase
      end else begin
        // SLL r0 no-ops
        inst = '0;
      end
      imem[k] = inst;
    end
  endtask

  task automatic run_test(input int test_no, input string name);
    int errors_before;
    int writes_before;
    errors_before = chk_errors + bench_errors;
    writes_before = chk_writes;
    rst_n         = 1'b0;
    random_wait   = (test_no >= 4);
    fill_program(test_no);
    repeat (5) step_cycle();
    rst_n = 1'b1;
    while (accepted < PROG_LEN) begin
      step_cycle();
    end
    // Last write trails its acceptance by three cycles
    repeat (4) step_cycle();
    end_check = 1'b1;
    step_cycle();
    end_check = 1'b0;
    step_cycle();
    if (chk_writes == writes_before) begin
      $display("test %0d produced no register writes at all", test_no);
      bench_errors++;
    end
    $display("test %0d (%s): %0d writes checked, %0d errors", test_no, name,
             chk_writes - writes_before, chk_errors + bench_errors - errors_before);
  endtask

  initial begin
    rst_n              = 1'b0;
    icache_waitrequest = 1'b0;
    icache_data        = '0;
    rd_data1           = '0;
    rd_data2           = '0;
    end_check          = 1'b0;
    random_wait        = 1'b0;
    bench_errors       = 0;
    rng_state          = 32'h82bf;
    run_test(1, "r-type alu ops");
    run_test(2, "immediate forms");
    run_test(3, "forwarding chains");
    run_test(4, "random wait request");
    run_test(5, "r0 and undefined ops");
    $display("tests: %0d, writes checked: %0d, errors: %0d",
             NUM_TESTS, chk_writes, chk_errors + bench_errors);
    if (chk_errors + bench_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/pip_pkg.sv
design/pip_fetch.sv
design/pip_alu.sv
design/pip_decode.sv
design/pip_execute.sv
design/pipeline.sv
bench/pip_checker.sv
bench/tb_pipeline.sv
